// ==== common/exec_pkg.sv ====
// exec_pkg
// shared definitions for the execute stage: word and shift-amount widths,
// operation codes, shifter modes and the layout of the flags word
`default_nettype none

package exec_pkg;

    localparam int data_width  = 16;  // datapath is fixed at 16 bits
    localparam int shamt_width = 4;   // shift amount 0..15
    localparam int flags_width = 3;   // zero, neg, carry

    // operation codes as seen on the issue port
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_ror  = 4'd8,
        op_pass = 4'd9   // forwards operand b, load-immediate with use_imm
    } op_t;

    // barrel shifter mode select, same encoding as the shifter mux
    typedef enum logic [1:0] {
        sh_sll = 2'b00,
        sh_srl = 2'b01,
        sh_sra = 2'b10,
        sh_ror = 2'b11
    } shift_mode_t;

    // bit positions inside the flags word
    localparam int flag_zero  = 0;
    localparam int flag_neg   = 1;
    localparam int flag_carry = 2;

endpackage

`default_nettype wire

// ==== verilog/shifter.sv ====
// shifter
// two-stage combinational barrel shifter for 16-bit words
// first stage moves by 0..3, second by 0/4/8/12, so any amount 0..15 works
// modes: logical left, logical right, arithmetic right, rotate right
`default_nettype none

module shifter (
    input  wire logic [exec_pkg::data_width-1:0]  data_in,
    input  wire logic [exec_pkg::shamt_width-1:0] shift_val,
    input  wire exec_pkg::shift_mode_t            mode,
    output logic [exec_pkg::data_width-1:0]       data_out
);
    import exec_pkg::*;

    logic [data_width-1:0] stage1;  // after the 0..3 stage
    logic [data_width-1:0] stage2;  // after the 0/4/8/12 stage
    logic                  sign;    // fill bit for arithmetic right

    assign sign = data_in[15];

    always_comb begin
        stage1 = data_in;  // amount 0 in both stages
        stage2 = data_in;
        case (mode)
            sh_sll: begin
                case (shift_val[1:0])
                    2'd0: stage1 = data_in;
                    2'd1: stage1 = {data_in[14:0], 1'b0};
                    2'd2: stage1 = {data_in[13:0], 2'b0};
                    2'd3: stage1 = {data_in[12:0], 3'b0};
                endcase
                case (shift_val[3:2])
                    2'd0: stage2 = stage1;
                    2'd1: stage2 = {stage1[11:0], 4'b0};
                    2'd2: stage2 = {stage1[7:0], 8'b0};
                    2'd3: stage2 = {stage1[3:0], 12'b0};  // true shift by 12
                endcase
            end
            sh_srl: begin
                case (shift_val[1:0])
                    2'd0: stage1 = data_in;
                    2'd1: stage1 = {1'b0, data_in[15:1]};
                    2'd2: stage1 = {2'b0, data_in[15:2]};
                    2'd3: stage1 = {3'b0, data_in[15:3]};
                endcase
                case (shift_val[3:2])
                    2'd0: stage2 = stage1;
                    2'd1: stage2 = {4'b0, stage1[15:4]};
                    2'd2: stage2 = {8'b0, stage1[15:8]};
                    2'd3: stage2 = {12'b0, stage1[15:12]};
                endcase
            end
            sh_sra: begin
                // fill always comes from the original msb
                case (shift_val[1:0])
                    2'd0: stage1 = data_in;
                    2'd1: stage1 = {sign, data_in[15:1]};
                    2'd2: stage1 = {{2{sign}}, data_in[15:2]};
                    2'd3: stage1 = {{3{sign}}, data_in[15:3]};
                endcase
                case (shift_val[3:2])
                    2'd0: stage2 = stage1;
                    2'd1: stage2 = {{4{sign}}, stage1[15:4]};
                    2'd2: stage2 = {{8{sign}}, stage1[15:8]};
                    2'd3: stage2 = {{12{sign}}, stage1[15:12]};
                endcase
            end
            sh_ror: begin
                case (shift_val[1:0])
                    2'd0: stage1 = data_in;
                    2'd1: stage1 = {data_in[0], data_in[15:1]};    // lsb wraps to msb
                    2'd2: stage1 = {data_in[1:0], data_in[15:2]};
                    2'd3: stage1 = {data_in[2:0], data_in[15:3]};
                endcase
                case (shift_val[3:2])
                    2'd0: stage2 = stage1;
                    2'd1: stage2 = {stage1[3:0], stage1[15:4]};
                    2'd2: stage2 = {stage1[7:0], stage1[15:8]};
                    2'd3: stage2 = {stage1[11:0], stage1[15:12]};
                endcase
            end
        endcase
    end

    assign data_out = stage2;

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
// alu
// combinational add/sub and logic unit
// add and sub share one 17-bit adder, sub inverts b and carries in a one
// shift ops take the barrel shifter output, carry only for add and sub
`default_nettype none

module alu (
    input  wire logic [exec_pkg::data_width-1:0] a,
    input  wire logic [exec_pkg::data_width-1:0] b,
    input  wire exec_pkg::op_t                   op,
    input  wire logic [exec_pkg::data_width-1:0] shift_result,
    output logic [exec_pkg::data_width-1:0]      alu_result,
    output logic                                 carry
);
    import exec_pkg::*;

    logic                  is_sub;   // selects a + ~b + 1
    logic [data_width-1:0] b_addend; // b or its complement
    logic [data_width:0]   sum;      // msb is the carry out

    assign is_sub   = (op == op_sub);
    assign b_addend = is_sub ? ~b : b;
    // for sub, carry out set means no borrow, i.e. a >= b unsigned
    assign sum      = {1'b0, a} + {1'b0, b_addend} + {{data_width{1'b0}}, is_sub};

    always_comb begin
        alu_result = '0;  // unused codes give zero
        carry      = 1'b0;
        case (op)
            op_add, op_sub: begin
                alu_result = sum[data_width-1:0];
                carry      = sum[data_width];
            end
            op_and:  alu_result = a & b;
            op_or:   alu_result = a | b;
            op_xor:  alu_result = a ^ b;
            op_sll, op_srl, op_sra, op_ror: begin
                alu_result = shift_result;  // mode already picked by the top
            end
            op_pass: alu_result = b;        // load-immediate or register move
            default: alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
// regfile
// num_regs x 16-bit register file
// two asynchronous read ports, one write port on the clock edge
// every register is cleared by the synchronous reset
`default_nettype none

module regfile #(
    parameter int num_regs = 8
) (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                we,
    input  wire logic [$clog2(num_regs)-1:0]         waddr,
    input  wire logic [exec_pkg::data_width-1:0]     wdata,
    input  wire logic [$clog2(num_regs)-1:0]         raddr_a,
    input  wire logic [$clog2(num_regs)-1:0]         raddr_b,
    output logic [exec_pkg::data_width-1:0]          rdata_a,
    output logic [exec_pkg::data_width-1:0]          rdata_b
);
    import exec_pkg::*;

    logic [data_width-1:0] regs [num_regs];  // storage array

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;  // architectural state starts at zero
            end
        end else if (we) begin
            regs[waddr] <= wdata;  // new value seen by reads after this edge
        end
    end

    // combinational reads, no bypass of the write port
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

// ==== verilog/exec_unit.sv ====
// exec_unit
// execute stage of the 16-bit load/store core
// an issue strobe reads the register file, runs the alu or shifter and
// writes the result back on the same edge
// result, flags and a one-cycle result_valid pulse follow one cycle later
`default_nettype none

module exec_unit #(
    parameter int num_regs = 8
) (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                issue,    // one-cycle strobe
    input  wire exec_pkg::op_t                       op,
    input  wire logic                                use_imm,  // sampled with issue
    input  wire logic [$clog2(num_regs)-1:0]         rd,
    input  wire logic [$clog2(num_regs)-1:0]         rs1,
    input  wire logic [$clog2(num_regs)-1:0]         rs2,
    input  wire logic [exec_pkg::data_width-1:0]     imm,
    output logic [exec_pkg::data_width-1:0]          result,
    output logic                                     result_valid,
    output logic [exec_pkg::flags_width-1:0]         flags
);
    import exec_pkg::*;

    logic [data_width-1:0]  rs1_data;
    logic [data_width-1:0]  rs2_data;
    logic [data_width-1:0]  operand_b;     // imm or rs2
    logic [data_width-1:0]  shift_out;
    logic [data_width-1:0]  alu_result;
    logic                   carry;
    shift_mode_t            shift_mode;
    logic [flags_width-1:0] next_flags;

    assign operand_b = use_imm ? imm : rs2_data;

    // op to shifter mode, don't care for non-shift ops
    always_comb begin
        case (op)
            op_srl:  shift_mode = sh_srl;
            op_sra:  shift_mode = sh_sra;
            op_ror:  shift_mode = sh_ror;
            default: shift_mode = sh_sll;
        endcase
    end

    regfile #(
        .num_regs (num_regs)
    ) i_regfile (
        .clk     (clk),
        .reset   (reset),
        .we      (issue),       // writeback at the issue edge
        .waddr   (rd),
        .wdata   (alu_result),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data)
    );

    shifter i_shifter (
        .data_in   (rs1_data),
        .shift_val (operand_b[shamt_width-1:0]),  // low bits give the amount
        .mode      (shift_mode),
        .data_out  (shift_out)
    );

    alu i_alu (
        .a            (rs1_data),
        .b            (operand_b),
        .op           (op),
        .shift_result (shift_out),
        .alu_result   (alu_result),
        .carry        (carry)
    );

    // flag word for the current operation
    always_comb begin
        next_flags             = '0;
        next_flags[flag_zero]  = (alu_result == '0);
        next_flags[flag_neg]   = alu_result[data_width-1];
        next_flags[flag_carry] = carry;  // alu already zeroes it for non add/sub
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result       <= '0;
            flags        <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue;  // pulse, no back-pressure
            if (issue) begin
                result <= alu_result;
                flags  <= next_flags;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/clock_gen.sv ====
// clock_gen
// free-running 100 ns clock and a synchronous reset held for 16 cycles
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #10 reset = 1'b0;  // released just after the 16th edge
    end

endmodule

`default_nettype wire

// ==== tb/exec_unit_asserts.sv ====
// exec_unit_asserts
// bound checks on the result_valid pulse and on the reset state of the outputs
`default_nettype none

module exec_unit_asserts (
    input wire logic                                clk,
    input wire logic                                reset,
    input wire logic                                issue,
    input wire logic                                result_valid,
    input wire logic [exec_pkg::data_width-1:0]     result,
    input wire logic [exec_pkg::flags_width-1:0]    flags
);
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    // a pulse lasting two cycles needs an issue in each of the two cycles before
    pulse_follows_issue: assert property (@(posedge clk) disable iff (reset)
        (result_valid && $past(result_valid)) |-> ($past(issue) && $past(issue, 2)))
        else $error("result_valid held without back-to-back issue");

    // low during reset and in the first cycle after it
    valid_low_in_reset: assert property (@(posedge clk) reset |=> !result_valid)
        else $error("result_valid high during or right after reset");

    outputs_clear_in_reset: assert property (@(posedge clk)
        reset |=> (result == '0 && flags == '0))
        else $error("result or flags not cleared by reset");

endmodule

`default_nettype wire

// ==== tb/exec_unit_tb.sv ====
// exec_unit_tb
// random operation stream against a register model of the execute stage
// every issue predicts result and flags, checked in the following cycle
`default_nettype none

module exec_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    localparam int num_regs   = 8;
    localparam int idx_w      = $clog2(num_regs);
    localparam int max_cycles = 2000;  // reset and all tests take about 1170 cycles

    logic                   clk, reset, issue, use_imm, result_valid;
    op_t                    op;
    logic [idx_w-1:0]       rd, rs1, rs2;
    logic [data_width-1:0]  imm, result;
    logic [flags_width-1:0] flags;

    integer seed = 32'h4c3cd547;
    int     errors = 0, checks = 0, errors_mark = 0, checks_mark = 0, cycles = 0;
    logic   issued_q = 1'b0;           // issue seen at the last edge
    logic [data_width-1:0]  model_regs [num_regs];
    logic [data_width-1:0]  exp_result [$];
    logic [flags_width-1:0] exp_flags  [$];
    op_t arith_ops [5] = '{op_add, op_sub, op_and, op_or, op_xor};
    op_t shift_ops [4] = '{op_sll, op_srl, op_sra, op_ror};

    clock_gen i_clock_gen (.clk(clk), .reset(reset));

    exec_unit #(.num_regs(num_regs)) i_exec_unit (
        .clk(clk), .reset(reset), .issue(issue), .op(op), .use_imm(use_imm),
        .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
        .result(result), .result_valid(result_valid), .flags(flags)
    );

    bind exec_unit exec_unit_asserts i_exec_unit_asserts (
        .clk(clk), .reset(reset), .issue(issue), .result_valid(result_valid),
        .result(result), .flags(flags)
    );

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // reference rules for one operation
    function automatic void predict(input op_t o, input logic [15:0] a, input logic [15:0] b,
                                    output logic [15:0] r, output logic [2:0] f);
        logic [16:0] wide;
        logic [31:0] dbl;
        int          amt;
        amt = b[3:0];
        f   = '0;
        case (o)
            op_add: begin
                wide = {1'b0, a} + {1'b0, b};
                r = wide[15:0];
                f[flag_carry] = wide[16];
            end
            op_sub: begin
                r = a - b;
                f[flag_carry] = (a >= b);  // no borrow
            end
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_xor:  r = a ^ b;
            op_sll:  r = a << amt;
            op_srl:  r = a >> amt;
            op_sra:  r = $signed(a) >>> amt;
            op_ror: begin
                dbl = {a, a} >> amt;  // low half is the rotated word
                r = dbl[15:0];
            end
            op_pass: r = b;
            default: r = '0;
        endcase
        f[flag_zero] = (r == 16'h0000);
        f[flag_neg]  = r[15];
    endfunction

    task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    // drive one issue, then return 10 ns after the edge that takes it
    task automatic do_issue(input op_t o, input int d, input int s1, input int s2,
                            input logic ui, input logic [15:0] im);
        logic [15:0] b;
        logic [15:0] r;
        logic [2:0]  f;
        b = ui ? im : model_regs[s2];
        predict(o, model_regs[s1], b, r, f);
        exp_result.push_back(r);
        exp_flags.push_back(f);
        model_regs[d] = r;  // writeback at the same edge
        issue   = 1'b1;
        op      = o;
        rd      = d;
        rs1     = s1;
        rs2     = s2;
        use_imm = ui;
        imm     = im;
        @(posedge clk);
        #10 issue = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    // one line per test once its last result is checked
    task automatic end_test(input string name);
        @(negedge clk);
        #1;
        $display("%s done: %0d checks, %0d errors", name, checks - checks_mark,
                 errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
        @(posedge clk);
        #10;  // back to the drive point
    endtask

    always @(posedge clk) begin
        issued_q <= issue && !reset;
        cycles   <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, run stopped", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // outputs are stable mid-cycle
    always @(negedge clk) begin
        if (!reset && issued_q) begin
            if (!result_valid) begin
                errors++;
                $display("missing result_valid pulse at %0t ns", $time);
            end
            check_value("result", result, exp_result[0]);
            check_value("flags", flags, exp_flags[0]);
            void'(exp_result.pop_front());
            void'(exp_flags.pop_front());
        end else if (!reset && result_valid) begin
            errors++;
            $display("unexpected result_valid pulse at %0t ns", $time);
        end
    end

    initial begin
        int a, k;
        issue   = 1'b0;
        op      = op_add;
        use_imm = 1'b0;
        rd      = '0;
        rs1     = '0;
        rs2     = '0;
        imm     = '0;
        for (int i = 0; i < num_regs; i++) model_regs[i] = '0;
        @(negedge reset);
        idle(2);

        // reset state with outputs clear and every register reading zero
        check_value("result", result, 16'h0);
        check_value("flags", flags, 16'h0);
        for (int i = 0; i < num_regs; i++) do_issue(op_pass, i, 0, i, 1'b0, $random(seed));
        end_test("reset state");

        // load every register then random arithmetic and logic
        for (int i = 0; i < num_regs; i++) do_issue(op_pass, i, 0, 0, 1'b1, $random(seed));
        for (int i = 0; i < 300; i++) begin
            do_issue(arith_ops[rand_below(5)], rand_below(num_regs), rand_below(num_regs),
                     rand_below(num_regs), rand_below(2), $random(seed));
        end
        end_test("load and arithmetic");

        // shifts with the sign bit set on every second preload
        // each mode sweeps its immediate amount through 0..15
        for (int i = 0; i < 300; i++) begin
            a = rand_below(num_regs);
            if (i % 2 == 0) do_issue(op_pass, a, 0, 0, 1'b1, $random(seed) | 16'h8000);
            if (i % 3 == 0) begin
                do_issue(shift_ops[i % 4], rand_below(num_regs), a, rand_below(num_regs),
                         1'b0, 16'h0);  // amount from rs2
            end else begin
                do_issue(shift_ops[i % 4], rand_below(num_regs), a, 0, 1'b1,
                         {12'($random(seed)), 4'(i / 4)});
            end
        end
        end_test("shifts");

        // each op reads the previous destination in the very next cycle
        a = rand_below(num_regs);
        do_issue(op_pass, a, 0, 0, 1'b1, $random(seed));
        for (int i = 0; i < 100; i++) begin
            k = rand_below(num_regs);
            do_issue(op_t'(rand_below(10)), k, a, rand_below(num_regs), rand_below(2),
                     $random(seed));
            a = k;
        end
        end_test("back-to-back");

        // idle gaps then a readback of every register
        for (int i = 0; i < 100; i++) begin
            idle(rand_below(4));
            do_issue(op_t'(rand_below(10)), rand_below(num_regs), rand_below(num_regs),
                     rand_below(num_regs), rand_below(2), $random(seed));
        end
        idle(3);
        for (int i = 0; i < num_regs; i++) do_issue(op_pass, i, 0, i, 1'b0, 16'h0);
        end_test("idle gaps");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/exec_pkg.sv
verilog/shifter.sv
verilog/alu.sv
verilog/regfile.sv
verilog/exec_unit.sv
tb/clock_gen.sv
tb/exec_unit_asserts.sv
tb/exec_unit_tb.sv

// ==== Bender.yml ====
package:
  name: exec_unit

sources:
  # shared package first
  - common/exec_pkg.sv
  # design
  - verilog/shifter.sv
  - verilog/alu.sv
  - verilog/regfile.sv
  - verilog/exec_unit.sv
  # testbench
  - target: test
    files:
      - tb/clock_gen.sv
      - tb/exec_unit_asserts.sv
      - tb/exec_unit_tb.sv
